/* hw/bus_cycle_unit.sv */
// cyc_start is ignored while a cycle runs; pins are decoded from registered phase state
`include "nand_params.svh"

module bus_cycle_unit import nand_pkg::*; (
	input  logic        clk,
	input  logic        nreset,
	input  logic        cyc_start,
	input  cycle_kind_e cyc_kind,
	input  logic [7:0]  cyc_wdata,
	input  logic [7:0]  nand_dq_in,
	output logic        cyc_done,
	output logic [7:0]  cyc_rdata,
	output logic        nand_cle,
	output logic        nand_ale,
	output logic        nand_nwe,
	output logic        nand_nre,
	output logic [7:0]  nand_dq_out,
	output logic        nand_dq_oe
);
	localparam int CYC_LEN = `NAND_T_SETUP + `NAND_T_PULSE + `NAND_T_HOLD;
	localparam int PH_W = $clog2(CYC_LEN);
	localparam logic [PH_W-1:0] PH_PULSE = PH_W'(`NAND_T_SETUP);
	localparam logic [PH_W-1:0] PH_HOLD = PH_W'(`NAND_T_SETUP + `NAND_T_PULSE);
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(CYC_LEN - 1);

	logic cyc_busy;
	logic [PH_W-1:0] phase;
	cycle_kind_e kind_q;
	logic [7:0] wdata_q;
	logic in_pulse;

	// phase 0 is the clock after cyc_start
	always_ff @(posedge clk) begin
		if (!nreset) begin
			cyc_busy <= 1'b0;
			phase <= '0;
		end else if (!cyc_busy) begin
			cyc_busy <= cyc_start;
			phase <= '0;
		end else if (phase == PH_LAST) begin
			cyc_busy <= 1'b0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!cyc_busy && cyc_start) begin
			kind_q <= cyc_kind;
			wdata_q <= cyc_wdata;
		end
		// last clock of the pulse, nRE still low
		if (cyc_busy && kind_q == CYC_READ && phase == PH_HOLD - 1'b1)
			cyc_rdata <= nand_dq_in;
	end

	// ------------------------------------------------
	// pin decode
	// ------------------------------------------------
	assign in_pulse = cyc_busy && phase >= PH_PULSE && phase < PH_HOLD;
	assign nand_cle = cyc_busy && kind_q == CYC_CMD;
	assign nand_ale = cyc_busy && kind_q == CYC_ADDR;
	// device latches dq on the rising nWE, data stays on through hold
	assign nand_nwe = !(in_pulse && kind_q != CYC_READ);
	assign nand_nre = !(in_pulse && kind_q == CYC_READ);
	assign nand_dq_oe = cyc_busy && kind_q != CYC_READ;
	assign nand_dq_out = wdata_q;
	assign cyc_done = cyc_busy && phase == PH_LAST;

	// a request during a running cycle would be dropped
	a_start_idle: assert property (@(posedge clk) disable iff (!nreset)
		cyc_start |-> !cyc_busy);

endmodule

/* hw/cmd_decode.sv */
// activate is only looked at while busy is low; invalid opcodes vanish without raising busy
module cmd_decode import nand_pkg::*; (
	input  logic       clk,
	input  logic       nreset,
	input  logic       activate,
	input  logic [5:0] cmd_in,
	input  logic [7:0] data_in,
	input  logic       seq_done,
	input  logic       reg_done,
	output logic       seq_start,
	output host_op_e   seq_op,
	output logic       reg_start,
	output host_op_e   reg_op,
	output logic [7:0] host_byte,
	output logic       busy
);
	host_op_e op_in;
	host_op_e op_q;
	logic op_valid;
	logic op_nand;
	logic accept;

	// sort the opcode into nand work, register work or junk
	always_comb begin
		op_in = host_op_e'(cmd_in);
		op_valid = 1'b0;
		op_nand = 1'b0;
		case (op_in)
			OP_RESET, OP_READ_ID, OP_READ_STATUS,
			OP_BYPASS_CMD, OP_BYPASS_ADDR, OP_BYPASS_WR, OP_BYPASS_RD: begin
				op_valid = 1'b1;
				op_nand = 1'b1;
			end
			OP_GET_STATUS, OP_CHIP_ENABLE, OP_CHIP_DISABLE,
			OP_RESET_INDEX, OP_GET_ID_BYTE: op_valid = 1'b1;
			default: op_valid = 1'b0;
		endcase
	end

	assign accept = activate && !busy && op_valid;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			busy <= 1'b0;
			seq_start <= 1'b0;
			reg_start <= 1'b0;
		end else begin
			seq_start <= accept && op_nand;
			reg_start <= accept && !op_nand;
			// busy drops the cycle after either unit reports done
			if (accept)
				busy <= 1'b1;
			else if (seq_done || reg_done)
				busy <= 1'b0;
		end
	end

	// opcode and host byte held for the whole operation
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= op_in;
			host_byte <= data_in;
		end
	end

	assign seq_op = op_q;
	assign reg_op = op_q;

	// a unit only reports done for an operation that is still open
	a_done_busy: assert property (@(posedge clk) disable iff (!nreset)
		(seq_done || reg_done) |-> busy);

endmodule

/* hw/nand_master.sv */
// x8 bus, dq split into out/oe/in for an external tristate; WP# is held low, no write support
module nand_master import nand_pkg::*; (
	input  logic       clk,
	input  logic       nreset,
	input  logic       activate,
	input  logic [5:0] cmd_in,
	input  logic [7:0] data_in,
	output logic [7:0] data_out,
	output logic       busy,
	output logic       nand_cle,
	output logic       nand_ale,
	output logic       nand_nwe,
	output logic       nand_nre,
	output logic       nand_nce,
	output logic       nand_nwp,
	input  logic       nand_rnb,
	output logic [7:0] nand_dq_out,
	output logic       nand_dq_oe,
	input  logic [7:0] nand_dq_in
);
	// ------------------------------------------------
	// internal links
	// ------------------------------------------------
	logic seq_start, seq_done, reg_start, reg_done;
	host_op_e seq_op, reg_op;
	logic [7:0] host_byte;
	logic cyc_start, cyc_done;
	cycle_kind_e cyc_kind;
	logic [7:0] cyc_wdata, cyc_rdata;
	logic id_wr, rd_byte_valid;
	logic [7:0] id_byte, rd_byte;

	// host opcode intake
	cmd_decode i_cmd_decode (.clk, .nreset, .activate, .cmd_in, .data_in, .seq_done, .reg_done,
		.seq_start, .seq_op, .reg_start, .reg_op, .host_byte, .busy);

	// nand operation steps
	op_sequencer i_op_sequencer (.clk, .nreset, .seq_start, .seq_op, .host_byte, .cyc_done,
		.cyc_rdata, .nand_rnb, .cyc_start, .cyc_kind, .cyc_wdata, .id_wr, .id_byte,
		.rd_byte_valid, .rd_byte, .seq_done);

	// pin level timing
	bus_cycle_unit i_bus_cycle_unit (.clk, .nreset, .cyc_start, .cyc_kind, .cyc_wdata,
		.nand_dq_in, .cyc_done, .cyc_rdata, .nand_cle, .nand_ale, .nand_nwe, .nand_nre,
		.nand_dq_out, .nand_dq_oe);

	// status, CE#, id store and host byte
	result_regs i_result_regs (.clk, .nreset, .reg_start, .reg_op, .id_wr, .id_byte,
		.rd_byte_valid, .rd_byte, .reg_done, .data_out, .nand_nce);

	// device stays write protected
	assign nand_nwp = 1'b0;

endmodule

/* hw/nand_params.svh */
// timing counts are in clk cycles and assume a clock slow enough for the device; x8 bus only
`ifndef NAND_PARAMS_SVH
`define NAND_PARAMS_SVH

// ------------------------------------------------
// pin cycle timing
// ------------------------------------------------
// CLE, ALE and dq settle before the strobe falls
`define NAND_T_SETUP 2
// nWE or nRE low time
`define NAND_T_PULSE 3
// bus held after the strobe rises
`define NAND_T_HOLD 2
// wait after the last command/address byte before R/B# means anything
`define NAND_T_WB 8
// status command to status read turnaround
`define NAND_T_WHR 6

// ------------------------------------------------
// device geometry and command bytes
// ------------------------------------------------
`define NAND_ID_BYTES 5
`define NAND_CMD_RESET 8'hff
`define NAND_CMD_READ_ID 8'h90
`define NAND_CMD_READ_STATUS 8'h70

`endif

/* hw/nand_pkg.sv */
// shared types only; opcode values are fixed by the host protocol and must not be renumbered
package nand_pkg;

	// host opcodes, anything else on cmd_in is dropped
	typedef enum logic [5:0] {
		OP_RESET        = 6'd1,
		OP_READ_ID      = 6'd2,
		OP_READ_STATUS  = 6'd3,
		OP_GET_STATUS   = 6'd4,
		OP_CHIP_ENABLE  = 6'd5,
		OP_CHIP_DISABLE = 6'd6,
		OP_RESET_INDEX  = 6'd7,
		OP_GET_ID_BYTE  = 6'd8,
		OP_BYPASS_CMD   = 6'd9,
		OP_BYPASS_ADDR  = 6'd10,
		OP_BYPASS_WR    = 6'd11,
		OP_BYPASS_RD    = 6'd12
	} host_op_e;

	// steps of a nand operation in the sequencer
	typedef enum logic [2:0] {
		SQ_IDLE, SQ_CMD, SQ_ADDR, SQ_WRITE, SQ_READ, SQ_DELAY, SQ_READY
	} seq_state_e;

	// one pin cycle on the nand bus
	typedef enum logic [1:0] {CYC_CMD, CYC_ADDR, CYC_WRITE, CYC_READ} cycle_kind_e;

	// controller status byte, bit 0 at the bottom
	typedef struct packed {
		logic [2:0] spare;
		logic       idx_oor;
		logic       write_prot;
		logic       chip_en;
		logic       wide_bus;
		logic       onfi;
	} status_t;

endpackage

/* hw/op_sequencer.sv */
// R/B# wait has no timeout, a dead device hangs the operation until nreset
`include "nand_params.svh"

module op_sequencer import nand_pkg::*; (
	input  logic        clk,
	input  logic        nreset,
	input  logic        seq_start,
	input  host_op_e    seq_op,
	input  logic [7:0]  host_byte,
	input  logic        cyc_done,
	input  logic [7:0]  cyc_rdata,
	input  logic        nand_rnb,
	output logic        cyc_start,
	output cycle_kind_e cyc_kind,
	output logic [7:0]  cyc_wdata,
	output logic        id_wr,
	output logic [7:0]  id_byte,
	output logic        rd_byte_valid,
	output logic [7:0]  rd_byte,
	output logic        seq_done
);
	localparam int DLY_W = $clog2(`NAND_T_WB + `NAND_T_WHR);
	localparam int CNT_W = $clog2(`NAND_ID_BYTES);
	localparam logic [DLY_W-1:0] WB_LOAD = DLY_W'(`NAND_T_WB - 1);
	localparam logic [DLY_W-1:0] WHR_LOAD = DLY_W'(`NAND_T_WHR - 1);
	localparam logic [CNT_W-1:0] LAST_ID = CNT_W'(`NAND_ID_BYTES - 1);

	seq_state_e state;
	host_op_e op_q;
	logic [DLY_W-1:0] dly_cnt;
	logic [CNT_W-1:0] byte_cnt;
	logic cyc_open;
	logic issue_en;
	cycle_kind_e issue_kind;
	logic [7:0] issue_byte;
	logic [7:0] rx_byte;

	// ------------------------------------------------
	// pin cycle request for the current step
	// ------------------------------------------------
	always_comb begin
		issue_kind = CYC_READ;
		issue_byte = host_byte;
		case (state)
			SQ_CMD: begin
				issue_kind = CYC_CMD;
				case (op_q)
					OP_RESET:       issue_byte = `NAND_CMD_RESET;
					OP_READ_ID:     issue_byte = `NAND_CMD_READ_ID;
					OP_READ_STATUS: issue_byte = `NAND_CMD_READ_STATUS;
					default:        issue_byte = host_byte;
				endcase
			end
			// read id always targets address 00h
			SQ_ADDR: begin
				issue_kind = CYC_ADDR;
				issue_byte = (op_q == OP_READ_ID) ? 8'h00 : host_byte;
			end
			SQ_WRITE: issue_kind = CYC_WRITE;
			default: issue_kind = CYC_READ;
		endcase
		// one request per step, the next only after the last one came back
		issue_en = (state == SQ_CMD || state == SQ_ADDR || state == SQ_WRITE ||
			state == SQ_READ) && !cyc_start && !cyc_open;
	end

	// ------------------------------------------------
	// step FSM
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= SQ_IDLE;
			cyc_start <= 1'b0;
			cyc_open <= 1'b0;
			id_wr <= 1'b0;
			rd_byte_valid <= 1'b0;
			seq_done <= 1'b0;
			dly_cnt <= '0;
			byte_cnt <= '0;
		end else begin
			cyc_start <= issue_en;
			id_wr <= 1'b0;
			rd_byte_valid <= 1'b0;
			seq_done <= 1'b0;
			if (cyc_start)
				cyc_open <= 1'b1;
			else if (cyc_done)
				cyc_open <= 1'b0;
			case (state)
				SQ_IDLE: if (seq_start) begin
					byte_cnt <= '0;
					case (seq_op)
						OP_BYPASS_ADDR: state <= SQ_ADDR;
						OP_BYPASS_WR:   state <= SQ_WRITE;
						OP_BYPASS_RD:   state <= SQ_READ;
						default:        state <= SQ_CMD;
					endcase
				end
				SQ_CMD: if (cyc_done) begin
					if (op_q == OP_RESET) begin
						dly_cnt <= WB_LOAD;
						state <= SQ_DELAY;
					end else if (op_q == OP_READ_STATUS) begin
						dly_cnt <= WHR_LOAD;
						state <= SQ_DELAY;
					end else if (op_q == OP_READ_ID) begin
						state <= SQ_ADDR;
					end else begin
						seq_done <= 1'b1;
						state <= SQ_IDLE;
					end
				end
				SQ_ADDR: if (cyc_done) begin
					if (op_q == OP_READ_ID) begin
						dly_cnt <= WB_LOAD;
						state <= SQ_DELAY;
					end else begin
						seq_done <= 1'b1;
						state <= SQ_IDLE;
					end
				end
				SQ_WRITE: if (cyc_done) begin
					seq_done <= 1'b1;
					state <= SQ_IDLE;
				end
				// status read needs no ready wait
				SQ_DELAY: begin
					if (dly_cnt == '0)
						state <= (op_q == OP_READ_STATUS) ? SQ_READ : SQ_READY;
					else
						dly_cnt <= dly_cnt - 1'b1;
				end
				SQ_READY: if (nand_rnb) begin
					if (op_q == OP_READ_ID) begin
						state <= SQ_READ;
					end else begin
						seq_done <= 1'b1;
						state <= SQ_IDLE;
					end
				end
				SQ_READ: if (cyc_done) begin
					if (op_q == OP_READ_ID) begin
						id_wr <= 1'b1;
						if (byte_cnt == LAST_ID) begin
							seq_done <= 1'b1;
							state <= SQ_IDLE;
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end else begin
						rd_byte_valid <= 1'b1;
						seq_done <= 1'b1;
						state <= SQ_IDLE;
					end
				end
				default: state <= SQ_IDLE;
			endcase
		end
	end

	// payload, no reset needed
	always_ff @(posedge clk) begin
		if (state == SQ_IDLE && seq_start)
			op_q <= seq_op;
		if (issue_en) begin
			cyc_kind <= issue_kind;
			cyc_wdata <= issue_byte;
		end
		if (cyc_done)
			rx_byte <= cyc_rdata;
	end

	// captured byte goes to either the id store or data_out
	assign id_byte = rx_byte;
	assign rd_byte = rx_byte;

	// cycle unit only reports back on a cycle that was asked for
	a_done_open: assert property (@(posedge clk) disable iff (!nreset)
		cyc_done |-> cyc_open);

endmodule

/* hw/result_regs.sv */
// id store holds the last read id result; index past the last id byte flags status bit 4
`include "nand_params.svh"

module result_regs import nand_pkg::*; (
	input  logic       clk,
	input  logic       nreset,
	input  logic       reg_start,
	input  host_op_e   reg_op,
	input  logic       id_wr,
	input  logic [7:0] id_byte,
	input  logic       rd_byte_valid,
	input  logic [7:0] rd_byte,
	output logic       reg_done,
	output logic [7:0] data_out,
	output logic       nand_nce
);
	localparam int IDX_W = $clog2(`NAND_ID_BYTES + 1);
	localparam logic [IDX_W-1:0] ID_LAST = IDX_W'(`NAND_ID_BYTES - 1);
	localparam logic [IDX_W-1:0] ID_COUNT = IDX_W'(`NAND_ID_BYTES);
	// write protected, chip off, x8, not onfi
	localparam status_t STATUS_RST = 8'h08;

	status_t status;
	logic [7:0] id_mem [`NAND_ID_BYTES];
	logic [IDX_W-1:0] id_wptr;
	logic [IDX_W-1:0] idx;

	// ------------------------------------------------
	// control registers
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			status <= STATUS_RST;
			nand_nce <= 1'b1;
			idx <= '0;
			id_wptr <= '0;
			reg_done <= 1'b0;
		end else begin
			reg_done <= reg_start;
			// wraps after the last byte so every read id starts at entry 0
			if (id_wr)
				id_wptr <= (id_wptr == ID_LAST) ? '0 : id_wptr + 1'b1;
			if (reg_start) begin
				case (reg_op)
					OP_CHIP_ENABLE: begin
						nand_nce <= 1'b0;
						status.chip_en <= 1'b1;
					end
					OP_CHIP_DISABLE: begin
						nand_nce <= 1'b1;
						status.chip_en <= 1'b0;
					end
					OP_RESET_INDEX: idx <= '0;
					OP_GET_ID_BYTE: begin
						if (idx < ID_COUNT) begin
							idx <= idx + 1'b1;
							status.idx_oor <= 1'b0;
						end else begin
							idx <= '0;
							status.idx_oor <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// id bytes and host output byte
	always_ff @(posedge clk) begin
		if (id_wr)
			id_mem[id_wptr] <= id_byte;
		if (reg_start) begin
			if (reg_op == OP_GET_STATUS)
				data_out <= status;
			else if (reg_op == OP_GET_ID_BYTE)
				data_out <= (idx < ID_COUNT) ? id_mem[idx] : 8'h00;
		end else if (rd_byte_valid) begin
			data_out <= rd_byte;
		end
	end

endmodule

/* list.f */
+incdir+hw
hw/nand_pkg.sv
hw/cmd_decode.sv
hw/op_sequencer.sv
hw/bus_cycle_unit.sv
hw/result_regs.sv
hw/nand_master.sv
tests/nand_chip_model.sv
tests/tb_nand_master.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, fail unless the pass line shows up
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_nand_master -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "Result: PASSED"

/* tests/nand_chip_model.sv */
// behavioral x8 device sampled on the falling clk edge; only reset, read id, read status and raw cycles
module nand_chip_model #(
	parameter logic [7:0] RAW_RD = 8'ha5
) (
	input  logic       clk,
	input  logic       nce,
	input  logic       cle,
	input  logic       ale,
	input  logic       nwe,
	input  logic       nre,
	input  logic [7:0] dq_wr,
	input  logic       dq_oe,
	output logic       rnb,
	output logic [7:0] dq_rd,
	output logic [7:0] last_cmd,
	output logic [7:0] last_addr,
	output logic [7:0] last_wr
);
	// R/B# low time after FFh, in clk cycles
	localparam int RESET_BUSY = 20;

	// what a data read returns
	typedef enum logic [1:0] {M_RAW, M_ID_ADDR, M_ID, M_STATUS} mode_e;

	mode_e mode = M_RAW;
	logic [2:0] ptr = 3'd0;
	int busy_cnt = 0;
	logic nwe_q = 1'b1;
	logic nre_q = 1'b1;
	logic [7:0] cmd_q = 8'h00;
	logic [7:0] addr_q = 8'h00;
	logic [7:0] wr_q = 8'h00;
	logic [7:0] bus_wr;

	assign rnb = (busy_cnt == 0);
	assign last_cmd = cmd_q;
	assign last_addr = addr_q;
	assign last_wr = wr_q;
	// undriven bus reads as unknown
	assign bus_wr = dq_oe ? dq_wr : 8'hxx;

	// ------------------------------------------------
	// read data, stable for the whole nRE low time
	// ------------------------------------------------
	always_comb begin
		case (mode)
			M_ID: begin
				case (ptr)
					3'd0: dq_rd = 8'h2c;
					3'd1: dq_rd = 8'hda;
					3'd2: dq_rd = 8'h90;
					3'd3: dq_rd = 8'h95;
					default: dq_rd = 8'h06;
				endcase
			end
			M_STATUS: dq_rd = 8'he0;
			default: dq_rd = RAW_RD;
		endcase
	end

	// ------------------------------------------------
	// strobe edges seen at the falling clk edge
	// ------------------------------------------------
	always @(negedge clk) begin
		nwe_q <= nwe;
		nre_q <= nre;
		if (busy_cnt != 0)
			busy_cnt <= busy_cnt - 1;
		// rising nWE latches cmd, address or data
		if (!nce && nwe && !nwe_q) begin
			if (cle) begin
				cmd_q <= bus_wr;
				case (bus_wr)
					8'hff: begin
						busy_cnt <= RESET_BUSY;
						mode <= M_RAW;
					end
					8'h90: mode <= M_ID_ADDR;
					8'h70: mode <= M_STATUS;
					default: mode <= M_RAW;
				endcase
			end else if (ale) begin
				addr_q <= bus_wr;
				if (mode == M_ID_ADDR && bus_wr == 8'h00) begin
					mode <= M_ID;
					ptr <= 3'd0;
				end
			end else begin
				wr_q <= bus_wr;
				mode <= M_RAW;
			end
		end
		// rising nRE moves to the next id byte, last one repeats
		if (!nce && nre && !nre_q && mode == M_ID && ptr != 3'd4)
			ptr <= ptr + 3'd1;
	end

endmodule

/* tests/tb_nand_master.sv */
// directed tests against the chip model; every wait gives up after OP_TIMEOUT clocks
`include "nand_params.svh"

module tb_nand_master import nand_pkg::*; ();
	localparam int OP_TIMEOUT = 400;
	localparam logic [7:0] RAW_BYTE = 8'h5c;

	logic clk;
	logic nreset;
	logic activate;
	logic [5:0] cmd_in;
	logic [7:0] data_in;
	logic [7:0] data_out;
	logic busy;
	logic nand_cle, nand_ale, nand_nwe, nand_nre, nand_nce, nand_nwp, nand_rnb;
	logic [7:0] nand_dq_out, nand_dq_in;
	logic nand_dq_oe;
	logic [7:0] chip_cmd, chip_addr, chip_wr;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	logic aborted = 1'b0;
	// expected controller state, tracked from the opcodes issued
	logic exp_ce = 1'b0;
	logic exp_oor = 1'b0;

	nand_master i_nand_master (.clk, .nreset, .activate, .cmd_in, .data_in, .data_out, .busy,
		.nand_cle, .nand_ale, .nand_nwe, .nand_nre, .nand_nce, .nand_nwp, .nand_rnb,
		.nand_dq_out, .nand_dq_oe, .nand_dq_in);

	nand_chip_model #(.RAW_RD(RAW_BYTE)) i_nand_chip_model (.clk, .nce(nand_nce),
		.cle(nand_cle), .ale(nand_ale), .nwe(nand_nwe), .nre(nand_nre), .dq_wr(nand_dq_out),
		.dq_oe(nand_dq_oe), .rnb(nand_rnb), .dq_rd(nand_dq_in), .last_cmd(chip_cmd),
		.last_addr(chip_addr), .last_wr(chip_wr));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------
	// helpers
	// ------------------------------------------------
	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	// status byte built from the register layout: wp set, x8, no onfi
	function automatic logic [7:0] status_expected();
		return {3'b000, exp_oor, 1'b1, exp_ce, 1'b0, 1'b0};
	endfunction

	function automatic logic [7:0] id_expected(input int i);
		case (i)
			0: return 8'h2c;
			1: return 8'hda;
			2: return 8'h90;
			3: return 8'h95;
			default: return 8'h06;
		endcase
	endfunction

	// nand pins between operations
	task automatic check_idle_pins();
		compare("nand_cle", {7'd0, nand_cle}, 8'h00);
		compare("nand_ale", {7'd0, nand_ale}, 8'h00);
		compare("nand_nwe", {7'd0, nand_nwe}, 8'h01);
		compare("nand_nre", {7'd0, nand_nre}, 8'h01);
		compare("nand_dq_oe", {7'd0, nand_dq_oe}, 8'h00);
		compare("nand_nwp", {7'd0, nand_nwp}, 8'h00);
	endtask

	// one activate pulse, then wait for the falling busy
	task automatic issue_op(input logic [5:0] op, input logic [7:0] arg);
		int n;
		@(posedge clk);
		activate <= 1'b1;
		cmd_in <= op;
		data_in <= arg;
		@(posedge clk);
		activate <= 1'b0;
		@(negedge clk);
		n = 0;
		while (busy && n < OP_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			errors++;
			aborted = 1'b1;
			$display("timeout: busy never fell after opcode %0d", op);
		end
	endtask

	task automatic report_test(input string name, input int errs0);
		tests++;
		if (errors == errs0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errs0);
	endtask

	// ------------------------------------------------
	// directed tests
	// ------------------------------------------------
	task automatic test_chip_enable();
		int errs0;
		errs0 = errors;
		issue_op(OP_GET_STATUS, 8'h00);
		compare("data_out", data_out, status_expected());
		compare("nand_nce", {7'd0, nand_nce}, 8'h01);
		check_idle_pins();
		issue_op(OP_CHIP_ENABLE, 8'h00);
		exp_ce = 1'b1;
		issue_op(OP_GET_STATUS, 8'h00);
		compare("data_out", data_out, status_expected());
		compare("nand_nce", {7'd0, nand_nce}, 8'h00);
		issue_op(OP_CHIP_DISABLE, 8'h00);
		exp_ce = 1'b0;
		issue_op(OP_GET_STATUS, 8'h00);
		compare("data_out", data_out, status_expected());
		compare("nand_nce", {7'd0, nand_nce}, 8'h01);
		report_test("chip enable", errs0);
	endtask

	task automatic test_read_id();
		int errs0;
		errs0 = errors;
		issue_op(OP_CHIP_ENABLE, 8'h00);
		exp_ce = 1'b1;
		issue_op(OP_RESET, 8'h00);
		issue_op(OP_READ_ID, 8'h00);
		// move the index off zero so reset_index has work to do
		issue_op(OP_GET_ID_BYTE, 8'h00);
		compare("data_out", data_out, id_expected(0));
		issue_op(OP_RESET_INDEX, 8'h00);
		for (int i = 0; i < `NAND_ID_BYTES; i++) begin
			issue_op(OP_GET_ID_BYTE, 8'h00);
			compare("data_out", data_out, id_expected(i));
		end
		// one past the end
		issue_op(OP_GET_ID_BYTE, 8'h00);
		exp_oor = 1'b1;
		compare("data_out", data_out, 8'h00);
		issue_op(OP_GET_STATUS, 8'h00);
		compare("data_out", data_out, status_expected());
		report_test("read id", errs0);
	endtask

	task automatic test_read_status();
		int errs0;
		errs0 = errors;
		issue_op(OP_READ_STATUS, 8'h00);
		compare("data_out", data_out, 8'he0);
		report_test("read status", errs0);
	endtask

	task automatic test_bypass();
		int errs0;
		logic [7:0] rnd_cmd;
		logic [7:0] rnd_addr;
		logic [7:0] rnd_data;
		errs0 = errors;
		// keep clear of the bytes the model treats as real commands
		rnd_cmd = 8'($urandom);
		while (rnd_cmd == 8'hff || rnd_cmd == 8'h90 || rnd_cmd == 8'h70)
			rnd_cmd = 8'($urandom);
		rnd_addr = 8'($urandom);
		rnd_data = 8'($urandom);
		issue_op(OP_BYPASS_CMD, rnd_cmd);
		compare("chip_cmd", chip_cmd, rnd_cmd);
		issue_op(OP_BYPASS_ADDR, rnd_addr);
		compare("chip_addr", chip_addr, rnd_addr);
		issue_op(OP_BYPASS_WR, rnd_data);
		compare("chip_wr", chip_wr, rnd_data);
		issue_op(OP_BYPASS_RD, 8'h00);
		compare("data_out", data_out, RAW_BYTE);
		check_idle_pins();
		report_test("bypass", errs0);
	endtask

	task automatic test_invalid_op();
		int errs0;
		errs0 = errors;
		@(posedge clk);
		activate <= 1'b1;
		cmd_in <= 6'h3f;
		@(posedge clk);
		activate <= 1'b0;
		repeat (10) begin
			@(negedge clk);
			compare("busy", {7'd0, busy}, 8'h00);
		end
		issue_op(OP_GET_STATUS, 8'h00);
		compare("data_out", data_out, status_expected());
		report_test("invalid opcode", errs0);
	endtask

	// ------------------------------------------------
	// main sequence
	// ------------------------------------------------
	initial begin
		nreset = 1'b0;
		activate = 1'b0;
		cmd_in = 6'd0;
		data_in = 8'h00;
		void'($urandom(32'hf14d));
		repeat (3) @(posedge clk);
		nreset <= 1'b1;
		if (!aborted)
			test_chip_enable();
		if (!aborted)
			test_read_id();
		if (!aborted)
			test_read_status();
		if (!aborted)
			test_bypass();
		if (!aborted)
			test_invalid_op();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
